/* rom_load_pkg.sv */
// rom loader package: shared widths, region codes, write FSM states and header layout
package rom_load_pkg;

    typedef logic [7:0]  byte_t;        // one download byte
    typedef logic [15:0] word_t;        // sdram word, region start in 1 KB units
    typedef logic [24:0] load_addr_t;   // download byte address, up to 32 MB
    typedef logic [21:0] sdram_addr_t;  // sdram word address
    typedef logic [2:0]  region_t;

    // region codes
    localparam region_t REGION_HDR  = 3'd0;
    localparam region_t REGION_CPU  = 3'd1;
    localparam region_t REGION_SND  = 3'd2;
    localparam region_t REGION_PCM  = 3'd3;
    localparam region_t REGION_GFX  = 3'd4;
    localparam region_t REGION_OVER = 3'd5;  // past the end start, load is done

    // program write FSM
    typedef enum logic {
        IDLE,
        WAIT_ACK
    } wr_state_t;

    // header layout
    localparam load_addr_t HEADER_BYTES = 25'd64;  // full header length
    localparam load_addr_t START_BYTES  = 25'd8;   // four 16-bit region starts
    localparam load_addr_t JOY_BYTE     = 25'd40;  // joystick mode byte

    // xor contribution of each data bit to the decrypted byte
    // bits 3 and 7 contribute when they are clear
    localparam byte_t DECRYPT_MASK [0:7] = '{
        8'h04,  // bit 0
        8'h21,  // bit 1
        8'h01,  // bit 2
        8'h50,  // bit 3, inverted
        8'h40,  // bit 4
        8'h06,  // bit 5
        8'h08,  // bit 6
        8'h88   // bit 7, inverted
    };

endpackage

/* rom_header_regs.sv */
// header register block: captures the region starts and decoded config fields
`timescale 1ns/10ps

module rom_header_regs
    import rom_load_pkg::*;
#(
    parameter int unsigned CFG_BYTE = 39  // byte with decrypt flag and key bit
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       downloading,
    input  logic       hdr_wr,
    input  load_addr_t hdr_addr,
    input  byte_t      hdr_data,
    output word_t      snd_start,
    output word_t      pcm_start,
    output word_t      gfx_start,
    output word_t      end_start,
    output logic       decrypt,
    output logic       key_bit,
    output logic [1:0] joymode
);

    byte_t start_bytes [0:7];  // header bytes 0 to 7, low byte first

    logic start_wr;
    logic cfg_hit;
    logic joy_hit;

    assign start_wr = hdr_wr && (hdr_addr < START_BYTES);
    assign cfg_hit  = hdr_wr && (hdr_addr == load_addr_t'(CFG_BYTE));
    assign joy_hit  = hdr_wr && (hdr_addr == JOY_BYTE);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                start_bytes[i] <= '0;
            end
        end else if (start_wr) begin
            start_bytes[hdr_addr[2:0]] <= hdr_data;
        end
    end

    assign snd_start = {start_bytes[1], start_bytes[0]};
    assign pcm_start = {start_bytes[3], start_bytes[2]};
    assign gfx_start = {start_bytes[5], start_bytes[4]};
    assign end_start = {start_bytes[7], start_bytes[6]};

    // decoded configuration fields
    always_ff @(posedge clk) begin
        if (rst) begin
            decrypt <= 1'b0;
            key_bit <= 1'b0;
            joymode <= 2'b00;
        end else begin
            if (!downloading) begin
                decrypt <= 1'b0;                 // flag only lives during a load
            end else if (cfg_hit) begin
                decrypt <= hdr_data[7];
                key_bit <= hdr_data[6];
            end
            if (joy_hit) begin
                joymode <= hdr_data[1:0];
            end
        end
    end

endmodule

/* rom_region_map.sv */
// region map: sorts bulk bytes into regions, rebases them and decrypts upper cpu bytes
`timescale 1ns/10ps

module rom_region_map
    import rom_load_pkg::*;
#(
    parameter sdram_addr_t CPU_OFFSET = 22'h0,
    parameter sdram_addr_t SND_OFFSET = 22'h0,
    parameter sdram_addr_t PCM_OFFSET = 22'h0,
    parameter sdram_addr_t GFX_OFFSET = 22'h0
) (
    input  load_addr_t  ioctl_addr,
    input  byte_t       ioctl_data,
    input  word_t       snd_start,
    input  word_t       pcm_start,
    input  word_t       gfx_start,
    input  word_t       end_start,
    input  logic        decrypt,
    input  logic        key_bit,
    output region_t     region,
    output sdram_addr_t map_addr,
    output logic [1:0]  map_ba,
    output byte_t       map_data
);

    // bits 3 and 7 add their mask when low
    localparam byte_t DECRYPT_INV = 8'h88;

    load_addr_t  bulk_addr;   // address with the header removed
    word_t       bulk_kb;     // bulk address in 1 KB units
    load_addr_t  region_base;
    load_addr_t  rel_addr;
    sdram_addr_t region_off;
    logic        do_decrypt;
    byte_t       dec_data;

    assign bulk_addr = ioctl_addr - HEADER_BYTES;
    assign bulk_kb   = {1'b0, bulk_addr[24:10]};

    // starts are checked in order, end start closes the download
    always_comb begin
        if (ioctl_addr < HEADER_BYTES) begin
            region = REGION_HDR;
        end else if (bulk_kb < snd_start) begin
            region = REGION_CPU;
        end else if (bulk_kb < pcm_start) begin
            region = REGION_SND;
        end else if (bulk_kb < gfx_start) begin
            region = REGION_PCM;
        end else if (bulk_kb < end_start) begin
            region = REGION_GFX;
        end else begin
            region = REGION_OVER;
        end
    end

    // rebase and bank per region
    always_comb begin
        case (region)
            REGION_CPU: begin
                region_base = '0;                       // cpu starts right after header
                region_off  = CPU_OFFSET;
                map_ba      = 2'd0;
            end
            REGION_SND: begin
                region_base = {snd_start[14:0], 10'd0};
                region_off  = SND_OFFSET;
                map_ba      = 2'd1;
            end
            REGION_PCM: begin
                region_base = {pcm_start[14:0], 10'd0};
                region_off  = PCM_OFFSET;
                map_ba      = 2'd1;                     // shares bank with sound
            end
            REGION_GFX: begin
                region_base = {gfx_start[14:0], 10'd0};
                region_off  = GFX_OFFSET;
                map_ba      = 2'd3;
            end
            default: begin
                region_base = '0;
                region_off  = '0;
                map_ba      = 2'd0;
            end
        endcase
    end

    assign rel_addr = bulk_addr - region_base;
    assign map_addr = rel_addr[22:1] + region_off;  // byte to word address

    // bit-wise xor decryption of the upper cpu half
    always_comb begin
        dec_data = '0;
        for (int i = 0; i < 8; i++) begin
            if (ioctl_data[i] ^ DECRYPT_INV[i]) begin
                dec_data = dec_data ^ DECRYPT_MASK[i];
            end
        end
    end

    assign do_decrypt = (region == REGION_CPU) && bulk_addr[19] && decrypt
                        && (bulk_addr[0] ^ key_bit);

    assign map_data = do_decrypt ? dec_data : ioctl_data;

endmodule

/* prog_write_ctrl.sv */
// program write control: byte handshake, sdram write stage, config pulse and busy flag
`timescale 1ns/10ps

module prog_write_ctrl
    import rom_load_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        downloading,
    input  logic        ioctl_valid,
    output logic        ioctl_ready,
    input  load_addr_t  ioctl_addr,
    input  byte_t       ioctl_data,
    input  logic        ioctl_ram,
    input  region_t     region,
    input  sdram_addr_t map_addr,
    input  logic [1:0]  map_ba,
    input  byte_t       map_data,
    output sdram_addr_t prog_addr,
    output word_t       prog_data,
    output logic [1:0]  prog_mask,   // active low
    output logic [1:0]  prog_ba,
    output logic        prog_we,
    input  logic        prog_rdy,
    output logic        hdr_wr,
    output logic        cfg_we,
    output logic [5:0]  cfg_addr,
    output byte_t       cfg_data,
    output logic        dump_wr,
    output logic        dwnld_busy
);

    wr_state_t state;

    logic accept;
    logic rom_acc;    // accepted byte belongs to the rom image
    logic bulk_acc;
    logic cfg_acc;

    assign ioctl_ready = (state == IDLE);  // held off while a write waits
    assign accept      = ioctl_valid && ioctl_ready;

    assign rom_acc  = accept && !ioctl_ram;
    assign dump_wr  = accept && ioctl_ram;
    assign hdr_wr   = rom_acc && (region == REGION_HDR);
    assign cfg_acc  = hdr_wr && (ioctl_addr >= START_BYTES);
    assign bulk_acc = rom_acc && (region != REGION_HDR) && (region != REGION_OVER);

    // write FSM, one sdram write per bulk byte
    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= IDLE;
            prog_we <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (bulk_acc) begin
                        state   <= WAIT_ACK;
                        prog_we <= 1'b1;
                    end
                end
                WAIT_ACK: begin
                    if (prog_rdy) begin
                        state   <= IDLE;
                        prog_we <= 1'b0;
                    end
                end
                default: begin
                    state   <= IDLE;
                    prog_we <= 1'b0;
                end
            endcase
        end
    end

    // write payload, held while the FSM waits
    always_ff @(posedge clk) begin
        if (bulk_acc) begin
            prog_addr <= map_addr;
            prog_data <= {2{map_data}};                       // byte on both lanes
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            prog_ba   <= map_ba;
        end
    end

    // config write port
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_we <= 1'b0;
        end else begin
            cfg_we <= cfg_acc;  // single cycle pulse
        end
    end

    always_ff @(posedge clk) begin
        if (cfg_acc) begin
            cfg_addr <= ioctl_addr[5:0];
            cfg_data <= ioctl_data;
        end
    end

    // busy from byte 0 until the load is over
    always_ff @(posedge clk) begin
        if (rst || !downloading) begin
            dwnld_busy <= 1'b0;
        end else if (rom_acc && (ioctl_addr == '0)) begin
            dwnld_busy <= 1'b1;
        end else if (rom_acc && (region == REGION_OVER)) begin
            dwnld_busy <= 1'b0;
        end
    end

endmodule

/* nvram_dump_port.sv */
// nvram dump bridge: packs 8-bit dump bytes into 16-bit words and reads bytes back
`timescale 1ns/10ps

module nvram_dump_port
    import rom_load_pkg::*;
#(
    parameter int NVRAM_AW = 7  // nvram word address width
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                dump_wr,
    input  load_addr_t          ioctl_addr,
    input  byte_t               ioctl_data,
    output logic [NVRAM_AW-1:0] dump_addr,
    output word_t               dump_din,
    output logic                dump_we,
    input  word_t               dump_dout,
    output byte_t               ioctl_data2sd
);

    // word address follows the byte address one cycle late,
    // so it lines up with the write pulse
    always_ff @(posedge clk) begin
        dump_addr <= ioctl_addr[NVRAM_AW:1];
    end

    always_ff @(posedge clk) begin
        if (dump_wr) begin
            if (ioctl_addr[0]) begin
                dump_din[15:8] <= ioctl_data;  // odd byte, upper lane
            end else begin
                dump_din[7:0] <= ioctl_data;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dump_we <= 1'b0;
        end else begin
            dump_we <= dump_wr;
        end
    end

    // read back lane
    assign ioctl_data2sd = ioctl_addr[0] ? dump_dout[15:8] : dump_dout[7:0];

endmodule

/* rom_loader.sv */
// rom loader top: download front end filling program sdram, config and nvram
`timescale 1ns/10ps

module rom_loader
    import rom_load_pkg::*;
#(
    parameter sdram_addr_t CPU_OFFSET = 22'h0,
    parameter sdram_addr_t SND_OFFSET = 22'h0,
    parameter sdram_addr_t PCM_OFFSET = 22'h0,
    parameter sdram_addr_t GFX_OFFSET = 22'h0,
    parameter int unsigned CFG_BYTE   = 39,
    parameter int          NVRAM_AW   = 7
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                downloading,
    // byte stream
    input  load_addr_t          ioctl_addr,
    input  byte_t               ioctl_data,
    input  logic                ioctl_ram,
    input  logic                ioctl_valid,
    output logic                ioctl_ready,
    output byte_t               ioctl_data2sd,
    // program sdram
    output sdram_addr_t         prog_addr,
    output word_t               prog_data,
    output logic [1:0]          prog_mask,
    output logic [1:0]          prog_ba,
    output logic                prog_we,
    input  logic                prog_rdy,
    // game configuration
    output logic                cfg_we,
    output logic [5:0]          cfg_addr,
    output byte_t               cfg_data,
    output logic [1:0]          joymode,
    output logic                dwnld_busy,
    // nvram
    output logic [NVRAM_AW-1:0] dump_addr,
    output word_t               dump_din,
    output logic                dump_we,
    input  word_t               dump_dout
);

    word_t       snd_start;
    word_t       pcm_start;
    word_t       gfx_start;
    word_t       end_start;
    logic        decrypt;
    logic        key_bit;
    logic        hdr_wr;
    logic        dump_wr;
    region_t     region;
    sdram_addr_t map_addr;
    logic [1:0]  map_ba;
    byte_t       map_data;

    rom_header_regs #(
        .CFG_BYTE (CFG_BYTE)
    ) u_header_regs (
        .clk         (clk),
        .rst         (rst),
        .downloading (downloading),
        .hdr_wr      (hdr_wr),
        .hdr_addr    (ioctl_addr),
        .hdr_data    (ioctl_data),
        .snd_start   (snd_start),
        .pcm_start   (pcm_start),
        .gfx_start   (gfx_start),
        .end_start   (end_start),
        .decrypt     (decrypt),
        .key_bit     (key_bit),
        .joymode     (joymode)
    );

    rom_region_map #(
        .CPU_OFFSET (CPU_OFFSET),
        .SND_OFFSET (SND_OFFSET),
        .PCM_OFFSET (PCM_OFFSET),
        .GFX_OFFSET (GFX_OFFSET)
    ) u_region_map (
        .ioctl_addr (ioctl_addr),
        .ioctl_data (ioctl_data),
        .snd_start  (snd_start),
        .pcm_start  (pcm_start),
        .gfx_start  (gfx_start),
        .end_start  (end_start),
        .decrypt    (decrypt),
        .key_bit    (key_bit),
        .region     (region),
        .map_addr   (map_addr),
        .map_ba     (map_ba),
        .map_data   (map_data)
    );

    prog_write_ctrl u_write_ctrl (
        .clk         (clk),
        .rst         (rst),
        .downloading (downloading),
        .ioctl_valid (ioctl_valid),
        .ioctl_ready (ioctl_ready),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_ram   (ioctl_ram),
        .region      (region),
        .map_addr    (map_addr),
        .map_ba      (map_ba),
        .map_data    (map_data),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_ba     (prog_ba),
        .prog_we     (prog_we),
        .prog_rdy    (prog_rdy),
        .hdr_wr      (hdr_wr),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .dump_wr     (dump_wr),
        .dwnld_busy  (dwnld_busy)
    );

    nvram_dump_port #(
        .NVRAM_AW (NVRAM_AW)
    ) u_dump_port (
        .clk           (clk),
        .rst           (rst),
        .dump_wr       (dump_wr),
        .ioctl_addr    (ioctl_addr),
        .ioctl_data    (ioctl_data),
        .dump_addr     (dump_addr),
        .dump_din      (dump_din),
        .dump_we       (dump_we),
        .dump_dout     (dump_dout),
        .ioctl_data2sd (ioctl_data2sd)
    );

endmodule

/* rom_loader_properties.sv */
// write control assertions: byte handshake, held program writes and strobe rules
`timescale 1ns/10ps

module rom_loader_properties
    import rom_load_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input wr_state_t   state,
    input logic        ioctl_ready,
    input load_addr_t  ioctl_addr,
    input sdram_addr_t prog_addr,
    input word_t       prog_data,
    input logic [1:0]  prog_mask,
    input logic [1:0]  prog_ba,
    input logic        prog_we,
    input logic        prog_rdy,
    input logic        cfg_we,
    input logic [5:0]  cfg_addr,
    input logic        dump_wr,
    input logic        dwnld_busy
);

    // a pending write keeps every field until the ack is seen
    write_held: assert property (@(posedge clk) disable iff (rst)
        prog_we && !prog_rdy |=> prog_we && $stable(prog_addr) && $stable(prog_data)
            && $stable(prog_mask) && $stable(prog_ba))
        else $error("program write dropped or changed before prog_rdy");

    // no byte may be taken while the sdram write is outstanding
    ready_low: assert property (@(posedge clk) disable iff (rst)
        prog_we |-> state == WAIT_ACK && !ioctl_ready)
        else $error("ioctl_ready high while a program write waits");

    // strobes on two edges in a row must come from two different bytes
    cfg_single: assert property (@(posedge clk) disable iff (rst)
        cfg_we |=> !cfg_we || (cfg_addr != $past(cfg_addr)))
        else $error("cfg_we repeated for the same byte");

    dump_single: assert property (@(posedge clk) disable iff (rst)
        dump_wr |=> !dump_wr || (ioctl_addr != $past(ioctl_addr)))
        else $error("dump write repeated for the same byte");

    reset_quiet: assert property (@(posedge clk)
        rst |=> !prog_we && !cfg_we && !dwnld_busy && ioctl_ready)
        else $error("control output active in reset");

endmodule

bind prog_write_ctrl rom_loader_properties u_properties (.*);

/* rom_loader_tb.sv */
// rom loader testbench: file driven download with a random delay sdram acknowledge
`timescale 1ns/10ps

module rom_loader_tb
    import rom_load_pkg::*;
();

    localparam int TIMEOUT = 50;  // cycles allowed for any wait
    localparam int CFG_POS = 39;

    logic        clk;
    logic        rst;
    logic        downloading;
    load_addr_t  ioctl_addr;
    byte_t       ioctl_data;
    logic        ioctl_ram;
    logic        ioctl_valid;
    logic        ioctl_ready;
    byte_t       ioctl_data2sd;
    sdram_addr_t prog_addr;
    word_t       prog_data;
    logic [1:0]  prog_mask;
    logic [1:0]  prog_ba;
    logic        prog_we;
    logic        prog_rdy;
    logic        cfg_we;
    logic [5:0]  cfg_addr;
    byte_t       cfg_data;
    logic [1:0]  joymode;
    logic        dwnld_busy;
    logic [6:0]  dump_addr;
    word_t       dump_din;
    logic        dump_we;
    word_t       dump_dout;

    logic [31:0] lfsr;
    logic        ack_wait;
    logic [2:0]  ack_delay;
    int          acks;
    int          writes;
    int          test_num;
    int          test_errors;
    logic        aborted;

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    rom_loader #(
        .CPU_OFFSET (22'h010000),
        .SND_OFFSET (22'h020000),
        .PCM_OFFSET (22'h030000),
        .GFX_OFFSET (22'h040000)
    ) uut (.*);

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // sdram side, acks each write after 0 to 7 extra cycles
    always @(posedge clk) begin
        prog_rdy <= 1'b0;
        if (rst) begin
            ack_wait <= 1'b0;
        end else if (ack_wait) begin
            if (ack_delay == 0) begin
                prog_rdy <= 1'b1;
                ack_wait <= 1'b0;
                acks     <= acks + 1;
            end else begin
                ack_delay <= ack_delay - 1'b1;
            end
        end else if (prog_we && !prog_rdy) begin
            ack_wait  <= 1'b1;
            ack_delay <= 3'(random_bits(3));
        end
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERR test %0d %s got %h expected %h", test_num, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("test %0d: timed out, %s", test_num, what);
        test_errors++;
        aborted = 1'b1;
    endtask

    function automatic logic strobe_value(input int sel);
        case (sel)
            0:       return prog_we;
            1:       return cfg_we;
            default: return dump_we;
        endcase
    endfunction

    // present a byte and hold it until the edge that takes it
    task automatic send_byte(input load_addr_t addr, input byte_t data, input logic ram);
        int n;
        n = 0;
        @(posedge clk);
        ioctl_valid <= 1'b1;
        ioctl_addr  <= addr;
        ioctl_data  <= data;
        ioctl_ram   <= ram;
        @(negedge clk);
        while (!ioctl_ready && n < TIMEOUT) begin
            if (!prog_we) begin
                $display("test %0d: ioctl_ready low with no write pending", test_num);
                test_errors++;
            end
            @(negedge clk);
            n++;
        end
        if (!ioctl_ready) begin
            report_timeout("ioctl_ready stayed low");
        end
        @(posedge clk);  // byte taken here
        ioctl_valid <= 1'b0;
    endtask

    // strobes are sampled at the falling edge
    task automatic wait_strobe(input int sel, input string name);
        int n;
        n = 0;
        @(negedge clk);
        while (!strobe_value(sel) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!strobe_value(sel)) begin
            report_timeout({name, " never went high"});
        end
    endtask

    // full 64 byte header, every config byte checked on the config port
    task automatic run_header(input byte_t cfg_byte, input word_t snd, input word_t pcm,
                              input word_t gfx, input word_t last);
        byte_t       hdr [0:63];
        logic [63:0] starts;
        starts = {last, gfx, pcm, snd};
        for (int a = 0; a < 64; a++) begin
            hdr[a] = {a[5:0], 2'b01} ^ 8'h5a;  // filler
        end
        for (int a = 0; a < 8; a++) begin
            hdr[a] = starts[a*8 +: 8];  // low byte first
        end
        hdr[CFG_POS] = cfg_byte;
        @(negedge clk);
        compare_value("dwnld_busy", dwnld_busy, 0);  // idle before byte 0
        for (int a = 0; a < 64 && !aborted; a++) begin
            send_byte(load_addr_t'(a), hdr[a], 1'b0);
            if (a >= 8) begin
                wait_strobe(1, "cfg_we");
                compare_value("cfg_addr", cfg_addr, a);
                compare_value("cfg_data", cfg_data, hdr[a]);
            end else begin
                @(negedge clk);
                compare_value("cfg_we", cfg_we, 0);  // start bytes are not config
            end
            compare_value("prog_we", prog_we, 0);
            compare_value("dwnld_busy", dwnld_busy, 1);
        end
        compare_value("joymode", joymode, hdr[40][1:0]);
    endtask

    task automatic run_record(input string kind, input logic [31:0] addr, data, ram,
                              input logic [31:0] exp_a, exp_b, exp_c, exp_d);
        if (kind == "hdr") begin
            run_header(data[7:0], exp_a[15:0], exp_b[15:0], exp_c[15:0], exp_d[15:0]);
        end else if (kind == "byte") begin
            send_byte(addr[24:0], data[7:0], ram[0]);
            wait_strobe(0, "prog_we");
            compare_value("prog_addr", prog_addr, exp_a);
            compare_value("prog_data", prog_data, exp_b);
            compare_value("prog_mask", prog_mask, exp_c);
            compare_value("prog_ba", prog_ba, exp_d);
            compare_value("dwnld_busy", dwnld_busy, 1);  // still loading
            writes++;
        end else if (kind == "over") begin
            send_byte(addr[24:0], data[7:0], ram[0]);
            for (int i = 0; i < 3; i++) begin
                @(negedge clk);
                compare_value("prog_we", prog_we, 0);  // no write past the end
            end
            compare_value("dwnld_busy", dwnld_busy, 0);
        end else if (kind == "ram") begin
            send_byte(addr[24:0], data[7:0], ram[0]);
            wait_strobe(2, "dump_we");
            compare_value("dump_addr", dump_addr, exp_a);
            compare_value("dump_din", dump_din & exp_c, exp_b & exp_c);
            @(negedge clk);
            compare_value("dump_we", dump_we, 0);  // single cycle pulse
        end else if (kind == "rd") begin
            @(posedge clk);
            ioctl_addr <= addr[24:0];
            dump_dout  <= data[15:0];
            @(negedge clk);
            compare_value("ioctl_data2sd", ioctl_data2sd, exp_a);
        end else begin
            $display("test %0d: unknown record kind %s", test_num, kind);
            test_errors++;
        end
    endtask

    initial begin
        int          fd;
        int          fields;
        int          tests;
        int          failed;
        int          errors;
        string       line;
        string       kind;
        logic [31:0] addr, data, ram, exp_a, exp_b, exp_c, exp_d;
        rst         = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_ram   = 1'b0;
        ioctl_valid = 1'b0;
        prog_rdy    = 1'b0;
        dump_dout   = '0;
        lfsr        = 32'he62e1876;
        acks        = 0;
        writes      = 0;
        tests       = 0;
        failed      = 0;
        errors      = 0;
        aborted     = 1'b0;
        repeat (4) @(posedge clk);
        rst         <= 1'b0;
        downloading <= 1'b1;
        fd = $fopen("rom_loader_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open rom_loader_tests.txt");
            errors++;
        end else begin
            while (!aborted && $fgets(line, fd) > 0) begin
                fields = $sscanf(line, "%d %s %h %h %h %h %h %h %h", test_num, kind,
                                 addr, data, ram, exp_a, exp_b, exp_c, exp_d);
                if (fields == 9) begin  // comment lines do not scan
                    test_errors = 0;
                    run_record(kind, addr, data, ram, exp_a, exp_b, exp_c, exp_d);
                    tests++;
                    errors += test_errors;
                    if (test_errors != 0) begin
                        failed++;
                    end
                    $display("test %0d %s: %s", test_num, kind,
                             (test_errors == 0) ? "ok" : "errors");
                end
            end
            $fclose(fd);
        end
        downloading <= 1'b0;
        @(negedge clk);
        if (acks != writes) begin
            $display("sdram saw %0d acknowledged writes, expected %0d", acks, writes);
            errors++;
        end
        $display("%0d tests run, %0d failed, %0d errors", tests, failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* flist.f */
rom_load_pkg.sv
rom_header_regs.sv
rom_region_map.sv
prog_write_ctrl.sv
nvram_dump_port.sv
rom_loader.sv
rom_loader_properties.sv
rom_loader_tb.sv

/* rom_loader_tests.txt */
# test kind addr data ram exp_a exp_b exp_c exp_d, numbers in hex except the test number
# hdr: data=config byte 39, exp=region starts | byte: exp=prog addr,data,mask,bank | ram: exp=dump_addr,din,din mask | rd: data=dump_dout, exp_a=byte
1 hdr 0 c0 0 0400 0410 0420 0440
2 byte 40 12 0 010000 1212 2 0
3 byte 41 34 0 010000 3434 1 0
4 byte 80040 a5 0 050000 5353 2 0
5 byte 80041 a5 0 050000 a5a5 1 0
6 byte 10003e 00 0 08ffff d8d8 2 0
7 byte 10003f 5a 0 08ffff 5a5a 1 0
8 byte 100040 77 0 020000 7777 2 1
9 byte 10403f 81 0 021fff 8181 1 1
10 byte 104040 9c 0 030000 9c9c 2 1
11 byte 10803f c3 0 031fff c3c3 1 1
12 byte 108040 e1 0 040000 e1e1 2 3
13 byte 11003f 1e 0 043fff 1e1e 1 3
14 over 110040 55 0 0 0 0 0
15 ram 10 3c 1 08 003c 00ff 0
16 ram 11 c3 1 08 c33c ffff 0
17 rd 11 beef 0 be 0 0 0
18 rd 10 beef 0 ef 0 0 0
